// File: rtl/scan_out_settings.svh
/* Address map and timing constants shared by the RTL and the testbench.
   SO_PWM_PERIOD must stay a multiple of 16 so every duty step is whole clocks. */

`ifndef SCAN_OUT_SETTINGS_SVH
`define SCAN_OUT_SETTINGS_SVH

// AXI4-Lite byte address width
`define SO_AXI_ADDR_W 4

// Only decoded address, anything else answers SLVERR
`define SO_CTRL_ADDR 4'h0

// Fan and LED PWM period in pclk_out cycles
`define SO_PWM_PERIOD 64

`endif

// File: rtl/scan_out_pkg.sv
/* Types shared by the output path. ctrl_cfg_t follows the control register
   bit for bit; reserved bits 7:6 are always stored and read as zero. */

package scan_out_pkg;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    // Value 3 is reserved and handled like RGSB
    typedef enum logic [1:0] {
        RGBHV = 2'd0,
        RGBCS = 2'd1,
        RGSB  = 2'd2
    } extra_out_mode_e;

    typedef enum logic [1:0] {
        OFF       = 2'd0,
        EXTRA_OUT = 2'd1,
        LEGACY_IN = 2'd2
    } exp_sel_e;

    typedef struct packed {
        logic [3:0]      led_duty;
        logic [3:0]      fan_duty;
        logic [1:0]      reserved;
        exp_sel_e        exp_sel;
        extra_out_mode_e extra_out_mode;
        logic            framelock;
        logic            poweron;
    } ctrl_cfg_t;

    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        SLVERR = 2'd2
    } axi_resp_e;

endpackage

// File: rtl/video_if.sv
/* One pixel per clock with its sync and data enable.
   No handshake, the sink must take every beat. */

interface video_if;

    scan_out_pkg::pixel_t pix;
    logic                 hsync;
    logic                 vsync;
    logic                 de;

    modport source (
        output pix,
        output hsync,
        output vsync,
        output de
    );

    modport sink (
        input pix,
        input hsync,
        input vsync,
        input de
    );

endinterface

// File: rtl/ctrl_regs.sv
/* AXI4-Lite slave, single outstanding write and read, 32-bit data bus.
   Only byte lanes 0 and 1 exist; other addresses answer SLVERR and read zero. */

`include "scan_out_settings.svh"

module ctrl_regs (
    input  logic                        pclk_out,
    input  logic                        po_reset_n,
    input  logic [`SO_AXI_ADDR_W-1:0]   awaddr_i,
    input  logic                        awvalid_i,
    output logic                        awready_o,
    input  logic [31:0]                 wdata_i,
    input  logic [3:0]                  wstrb_i,
    input  logic                        wvalid_i,
    output logic                        wready_o,
    output scan_out_pkg::axi_resp_e     bresp_o,
    output logic                        bvalid_o,
    input  logic                        bready_i,
    input  logic [`SO_AXI_ADDR_W-1:0]   araddr_i,
    input  logic                        arvalid_i,
    output logic                        arready_o,
    output logic [31:0]                 rdata_o,
    output scan_out_pkg::axi_resp_e     rresp_o,
    output logic                        rvalid_o,
    input  logic                        rready_i,
    output scan_out_pkg::ctrl_cfg_t     cfg_o
);

    scan_out_pkg::ctrl_cfg_t cfg_q;
    scan_out_pkg::ctrl_cfg_t cfg_wr;
    logic [15:0]             wr_merge;
    logic                    wr_rdy;
    logic                    rd_rdy;
    logic                    wr_hs;
    logic                    rd_hs;
    logic                    wr_hit;
    logic                    rd_hit;

    assign awready_o = wr_rdy;
    assign wready_o  = wr_rdy;
    assign arready_o = rd_rdy;
    assign cfg_o     = cfg_q;

    // Address and data are taken together in one beat
    assign wr_hs  = wr_rdy & awvalid_i & wvalid_i;
    assign rd_hs  = rd_rdy & arvalid_i;
    assign wr_hit = (awaddr_i == `SO_CTRL_ADDR);
    assign rd_hit = (araddr_i == `SO_CTRL_ADDR);

    // Merge strobed bytes into the current value
    always_comb begin
        wr_merge = cfg_q;
        if (wstrb_i[0]) begin
            wr_merge[7:0] = wdata_i[7:0];
        end
        if (wstrb_i[1]) begin
            wr_merge[15:8] = wdata_i[15:8];
        end
        cfg_wr          = scan_out_pkg::ctrl_cfg_t'(wr_merge);
        cfg_wr.reserved = '0;
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            wr_rdy   <= 1'b0;
            rd_rdy   <= 1'b0;
            bvalid_o <= 1'b0;
            rvalid_o <= 1'b0;
            cfg_q    <= '0;
        end else begin
            // Single-cycle ready pulses, blocked while a response waits
            wr_rdy <= !wr_rdy && awvalid_i && wvalid_i && !bvalid_o;
            rd_rdy <= !rd_rdy && arvalid_i && !rvalid_o;

            if (wr_hs && wr_hit) begin
                cfg_q <= cfg_wr;
            end

            if (wr_hs) begin
                bvalid_o <= 1'b1;
            end else if (bready_i) begin
                bvalid_o <= 1'b0;
            end

            if (rd_hs) begin
                rvalid_o <= 1'b1;
            end else if (rready_i) begin
                rvalid_o <= 1'b0;
            end
        end
    end

    // Response payload only moves on a handshake
    always_ff @(posedge pclk_out) begin
        if (wr_hs) begin
            if (wr_hit) begin
                bresp_o <= scan_out_pkg::OKAY;
            end else begin
                bresp_o <= scan_out_pkg::SLVERR;
            end
        end
        if (rd_hs) begin
            if (rd_hit) begin
                rdata_o <= {16'h0000, cfg_q};
                rresp_o <= scan_out_pkg::OKAY;
            end else begin
                rdata_o <= '0;
                rresp_o <= scan_out_pkg::SLVERR;
            end
        end
    end

endmodule

// File: rtl/osd_mixer.sv
/* OSD colour replaces the scaler pixel while osd_enable_i is high.
   Stage 1 feeds the expansion path, stage 2 drives the HDMI transmitter. */

module osd_mixer (
    input  logic                    pclk_out,
    input  logic                    po_reset_n,
    input  scan_out_pkg::ctrl_cfg_t cfg_i,
    input  scan_out_pkg::pixel_t    pix_i,
    input  logic                    hsync_i,
    input  logic                    vsync_i,
    input  logic                    de_i,
    input  logic                    osd_enable_i,
    input  logic [2:0]              osd_color_i,
    video_if.source                 vid_o,
    output scan_out_pkg::pixel_t    hdmi_pix_o,
    output logic                    hdmi_hsync_o,
    output logic                    hdmi_vsync_o,
    output logic                    hdmi_de_o,
    output logic                    tx_5v_en_o
);

    scan_out_pkg::pixel_t osd_pix;
    scan_out_pkg::pixel_t mix_pix;
    scan_out_pkg::pixel_t s1_pix;
    logic                 s1_hsync;
    logic                 s1_vsync;
    logic                 s1_de;

    // Colour bits 2..0 select full or zero R, G, B
    always_comb begin
        osd_pix.r = {8{osd_color_i[2]}};
        osd_pix.g = {8{osd_color_i[1]}};
        osd_pix.b = {8{osd_color_i[0]}};
        mix_pix   = osd_enable_i ? osd_pix : pix_i;
    end

    always_ff @(posedge pclk_out) begin
        s1_pix     <= mix_pix;
        hdmi_pix_o <= s1_pix;
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            s1_hsync     <= 1'b0;
            s1_vsync     <= 1'b0;
            s1_de        <= 1'b0;
            hdmi_hsync_o <= 1'b0;
            hdmi_vsync_o <= 1'b0;
            hdmi_de_o    <= 1'b0;
            tx_5v_en_o   <= 1'b0;
        end else begin
            s1_hsync     <= hsync_i;
            s1_vsync     <= vsync_i;
            s1_de        <= de_i;
            hdmi_hsync_o <= s1_hsync;
            hdmi_vsync_o <= s1_vsync;
            hdmi_de_o    <= s1_de;
            tx_5v_en_o   <= cfg_i.poweron;
        end
    end

    assign vid_o.pix   = s1_pix;
    assign vid_o.hsync = s1_hsync;
    assign vid_o.vsync = s1_vsync;
    assign vid_o.de    = s1_de;

endmodule

// File: rtl/extra_out_encoder.sv
/* Analog expansion output, RGBHV / RGBCS / RGsB only (no YPbPr converter).
   Both stages freeze unless exp_sel is EXTRA_OUT; mode 3 behaves as RGsB. */

module extra_out_encoder (
    input  logic                    pclk_out,
    input  logic                    po_reset_n,
    input  scan_out_pkg::ctrl_cfg_t cfg_i,
    video_if.sink                   vid_i,
    output scan_out_pkg::pixel_t    vga_pix_o,
    output logic                    vga_hs_o,
    output logic                    vga_vs_o,
    output logic                    vga_blank_n_o,
    output logic                    vga_sync_n_o,
    output logic                    vga_oe_o
);

    scan_out_pkg::pixel_t pix_pre;
    logic                 enable;
    logic                 csync;
    logic                 hs_fmt;
    logic                 vs_fmt;
    logic                 sync_n_fmt;
    logic                 hs_pre;
    logic                 vs_pre;
    logic                 blank_n_pre;
    logic                 sync_n_pre;

    assign enable   = (cfg_i.exp_sel == scan_out_pkg::EXTRA_OUT);
    assign vga_oe_o = enable;

    // Composite sync, high outside both pulses
    assign csync = ~(vid_i.hsync ^ vid_i.vsync);

    always_comb begin
        if (cfg_i.extra_out_mode == scan_out_pkg::RGBHV) begin
            hs_fmt = vid_i.hsync;
            vs_fmt = vid_i.vsync;
        end else begin
            hs_fmt = csync;
            vs_fmt = 1'b1;
        end
        // Sync on green for RGsB and the reserved code
        sync_n_fmt = (cfg_i.extra_out_mode >= scan_out_pkg::RGSB) ? csync : 1'b0;
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            pix_pre       <= '0;
            hs_pre        <= 1'b0;
            vs_pre        <= 1'b0;
            blank_n_pre   <= 1'b0;
            sync_n_pre    <= 1'b0;
            vga_pix_o     <= '0;
            vga_hs_o      <= 1'b0;
            vga_vs_o      <= 1'b0;
            vga_blank_n_o <= 1'b0;
            vga_sync_n_o  <= 1'b0;
        end else if (enable) begin
            pix_pre       <= vid_i.pix;
            hs_pre        <= hs_fmt;
            vs_pre        <= vs_fmt;
            blank_n_pre   <= vid_i.de;
            sync_n_pre    <= sync_n_fmt;
            vga_pix_o     <= pix_pre;
            vga_hs_o      <= hs_pre;
            vga_vs_o      <= vs_pre;
            vga_blank_n_o <= blank_n_pre;
            vga_sync_n_o  <= sync_n_pre;
        end
    end

endmodule

// File: rtl/pwm_2ch.sv
/* Fan and LED PWM from one free-running counter, 16 duty steps per period.
   PERIOD must be a multiple of 16. */

`include "scan_out_settings.svh"

module pwm_2ch #(
    parameter int PERIOD = `SO_PWM_PERIOD
) (
    input  logic                    pclk_out,
    input  logic                    po_reset_n,
    input  scan_out_pkg::ctrl_cfg_t cfg_i,
    output logic                    fan_pwm_n_o,
    output logic [2:0]              led_o
);

    localparam int CW   = $clog2(PERIOD);
    localparam int STEP = PERIOD / 16;

    logic [CW-1:0] cnt;
    logic [CW:0]   fan_thr;
    logic [CW:0]   led_thr;
    logic          fan_ch;
    logic          led_ch;

    assign fan_thr = (CW+1)'(cfg_i.fan_duty * STEP);
    assign led_thr = (CW+1)'(cfg_i.led_duty * STEP);

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            cnt    <= '0;
            fan_ch <= 1'b0;
            led_ch <= 1'b0;
        end else begin
            if (cnt == CW'(PERIOD - 1)) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
            fan_ch <= ({1'b0, cnt} < fan_thr);
            led_ch <= ({1'b0, cnt} < led_thr);
        end
    end

    // Fan driver is active low, off while powered down
    assign fan_pwm_n_o = ~(cfg_i.poweron & fan_ch);

    // Standby LED on bit 0, framelock on bit 2
    assign led_o = {3{led_ch}} & {cfg_i.framelock & cfg_i.poweron,
                                  cfg_i.poweron,
                                  ~cfg_i.poweron};

endmodule

// File: rtl/scan_out_top.sv
/* Output side of the scan converter, all on pclk_out with po_reset_n.
   Control comes from one AXI4-Lite register at SO_CTRL_ADDR. */

`include "scan_out_settings.svh"

module scan_out_top (
    input  logic                        pclk_out,
    input  logic                        po_reset_n,
    input  logic [`SO_AXI_ADDR_W-1:0]   s_axi_awaddr_i,
    input  logic                        s_axi_awvalid_i,
    output logic                        s_axi_awready_o,
    input  logic [31:0]                 s_axi_wdata_i,
    input  logic [3:0]                  s_axi_wstrb_i,
    input  logic                        s_axi_wvalid_i,
    output logic                        s_axi_wready_o,
    output scan_out_pkg::axi_resp_e     s_axi_bresp_o,
    output logic                        s_axi_bvalid_o,
    input  logic                        s_axi_bready_i,
    input  logic [`SO_AXI_ADDR_W-1:0]   s_axi_araddr_i,
    input  logic                        s_axi_arvalid_i,
    output logic                        s_axi_arready_o,
    output logic [31:0]                 s_axi_rdata_o,
    output scan_out_pkg::axi_resp_e     s_axi_rresp_o,
    output logic                        s_axi_rvalid_o,
    input  logic                        s_axi_rready_i,
    input  logic [7:0]                  sc_r_i,
    input  logic [7:0]                  sc_g_i,
    input  logic [7:0]                  sc_b_i,
    input  logic                        sc_hsync_i,
    input  logic                        sc_vsync_i,
    input  logic                        sc_de_i,
    input  logic                        osd_enable_i,
    input  logic [2:0]                  osd_color_i,
    output logic [7:0]                  hdmitx_r_o,
    output logic [7:0]                  hdmitx_g_o,
    output logic [7:0]                  hdmitx_b_o,
    output logic                        hdmitx_hsync_o,
    output logic                        hdmitx_vsync_o,
    output logic                        hdmitx_de_o,
    output logic                        hdmitx_5v_en_o,
    output logic [7:0]                  vga_r_o,
    output logic [7:0]                  vga_g_o,
    output logic [7:0]                  vga_b_o,
    output logic                        vga_hs_o,
    output logic                        vga_vs_o,
    output logic                        vga_blank_n_o,
    output logic                        vga_sync_n_o,
    output logic                        vga_oe_o,
    output logic                        fan_pwm_n_o,
    output logic [2:0]                  led_o
);

    scan_out_pkg::ctrl_cfg_t cfg;
    scan_out_pkg::pixel_t    hdmi_pix;
    scan_out_pkg::pixel_t    vga_pix;

    video_if u_vid_if ();

    ctrl_regs u_ctrl_regs (
        .pclk_out   (pclk_out),
        .po_reset_n (po_reset_n),
        .awaddr_i   (s_axi_awaddr_i),
        .awvalid_i  (s_axi_awvalid_i),
        .awready_o  (s_axi_awready_o),
        .wdata_i    (s_axi_wdata_i),
        .wstrb_i    (s_axi_wstrb_i),
        .wvalid_i   (s_axi_wvalid_i),
        .wready_o   (s_axi_wready_o),
        .bresp_o    (s_axi_bresp_o),
        .bvalid_o   (s_axi_bvalid_o),
        .bready_i   (s_axi_bready_i),
        .araddr_i   (s_axi_araddr_i),
        .arvalid_i  (s_axi_arvalid_i),
        .arready_o  (s_axi_arready_o),
        .rdata_o    (s_axi_rdata_o),
        .rresp_o    (s_axi_rresp_o),
        .rvalid_o   (s_axi_rvalid_o),
        .rready_i   (s_axi_rready_i),
        .cfg_o      (cfg)
    );

    osd_mixer u_osd_mixer (
        .pclk_out     (pclk_out),
        .po_reset_n   (po_reset_n),
        .cfg_i        (cfg),
        .pix_i        ({sc_r_i, sc_g_i, sc_b_i}),
        .hsync_i      (sc_hsync_i),
        .vsync_i      (sc_vsync_i),
        .de_i         (sc_de_i),
        .osd_enable_i (osd_enable_i),
        .osd_color_i  (osd_color_i),
        .vid_o        (u_vid_if.source),
        .hdmi_pix_o   (hdmi_pix),
        .hdmi_hsync_o (hdmitx_hsync_o),
        .hdmi_vsync_o (hdmitx_vsync_o),
        .hdmi_de_o    (hdmitx_de_o),
        .tx_5v_en_o   (hdmitx_5v_en_o)
    );

    extra_out_encoder u_extra_out_encoder (
        .pclk_out      (pclk_out),
        .po_reset_n    (po_reset_n),
        .cfg_i         (cfg),
        .vid_i         (u_vid_if.sink),
        .vga_pix_o     (vga_pix),
        .vga_hs_o      (vga_hs_o),
        .vga_vs_o      (vga_vs_o),
        .vga_blank_n_o (vga_blank_n_o),
        .vga_sync_n_o  (vga_sync_n_o),
        .vga_oe_o      (vga_oe_o)
    );

    pwm_2ch #(
        .PERIOD (`SO_PWM_PERIOD)
    ) u_pwm_2ch (
        .pclk_out    (pclk_out),
        .po_reset_n  (po_reset_n),
        .cfg_i       (cfg),
        .fan_pwm_n_o (fan_pwm_n_o),
        .led_o       (led_o)
    );

    assign hdmitx_r_o = hdmi_pix.r;
    assign hdmitx_g_o = hdmi_pix.g;
    assign hdmitx_b_o = hdmi_pix.b;
    assign vga_r_o    = vga_pix.r;
    assign vga_g_o    = vga_pix.g;
    assign vga_b_o    = vga_pix.b;

endmodule

// File: sim/scan_out_asserts.sv
/* Protocol and hold checks bound into scan_out_top, disabled during reset */

module scan_out_asserts (
    input logic        pclk_out,
    input logic        po_reset_n,
    input logic        bvalid,
    input logic        bready,
    input logic [1:0]  bresp,
    input logic        rvalid,
    input logic        rready,
    input logic [31:0] rdata,
    input logic        vga_oe,
    input logic [27:0] vga_bus
);
    timeunit 1ns;
    timeprecision 1ps;

    // Write response held until taken
    a_bresp_hold: assert property (@(posedge pclk_out) disable iff (!po_reset_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("write response changed before bready");

    a_rdata_hold: assert property (@(posedge pclk_out) disable iff (!po_reset_n)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("read data changed before rready");

    // Expansion outputs frozen while disabled
    a_vga_hold: assert property (@(posedge pclk_out) disable iff (!po_reset_n)
        !vga_oe |=> $stable(vga_bus))
        else $error("vga outputs moved with vga_oe_o low");

endmodule

bind scan_out_top scan_out_asserts u_scan_out_asserts (
    .pclk_out   (pclk_out),
    .po_reset_n (po_reset_n),
    .bvalid     (s_axi_bvalid_o),
    .bready     (s_axi_bready_i),
    .bresp      (s_axi_bresp_o),
    .rvalid     (s_axi_rvalid_o),
    .rready     (s_axi_rready_i),
    .rdata      (s_axi_rdata_o),
    .vga_oe     (vga_oe_o),
    .vga_bus    ({vga_r_o, vga_g_o, vga_b_o, vga_hs_o, vga_vs_o, vga_blank_n_o, vga_sync_n_o})
);

// File: sim/scan_out_tb.sv
/* Self-checking testbench for scan_out_top. Outputs are sampled on the falling
   edge; the run stops at the first mismatch or after 20000 cycles. */

`include "scan_out_settings.svh"

module scan_out_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic pclk_out = 1'b0;
    logic po_reset_n;
    logic [`SO_AXI_ADDR_W-1:0] awaddr, araddr;
    logic awvalid, wvalid, bready, arvalid, rready;
    logic [31:0] wdata;
    logic [3:0] wstrb;
    logic [7:0] sc_r, sc_g, sc_b;
    logic sc_hs, sc_vs, sc_de, osd_en;
    logic [2:0] osd_col;
    logic awready, wready, bvalid, arready, rvalid;
    scan_out_pkg::axi_resp_e bresp, rresp;
    logic [31:0] rdata;
    logic [7:0] tx_r, tx_g, tx_b, v_r, v_g, v_b;
    logic tx_hs, tx_vs, tx_de, tx_5v, v_hs, v_vs, v_blank_n, v_sync_n, v_oe, fan_n;
    logic [2:0] led;

    int seed = 32'habff_0ef9;
    int cycles = 0;
    bit hdmi_chk = 0;
    bit vga_chk = 0;
    scan_out_pkg::ctrl_cfg_t cfg_model = '0;
    logic [26:0] hq[$];
    logic [27:0] vq[$];

    scan_out_top u_scan_out_top (
        .pclk_out(pclk_out), .po_reset_n(po_reset_n),
        .s_axi_awaddr_i(awaddr), .s_axi_awvalid_i(awvalid), .s_axi_awready_o(awready),
        .s_axi_wdata_i(wdata), .s_axi_wstrb_i(wstrb), .s_axi_wvalid_i(wvalid),
        .s_axi_wready_o(wready), .s_axi_bresp_o(bresp), .s_axi_bvalid_o(bvalid),
        .s_axi_bready_i(bready), .s_axi_araddr_i(araddr), .s_axi_arvalid_i(arvalid),
        .s_axi_arready_o(arready), .s_axi_rdata_o(rdata), .s_axi_rresp_o(rresp),
        .s_axi_rvalid_o(rvalid), .s_axi_rready_i(rready),
        .sc_r_i(sc_r), .sc_g_i(sc_g), .sc_b_i(sc_b), .sc_hsync_i(sc_hs),
        .sc_vsync_i(sc_vs), .sc_de_i(sc_de), .osd_enable_i(osd_en), .osd_color_i(osd_col),
        .hdmitx_r_o(tx_r), .hdmitx_g_o(tx_g), .hdmitx_b_o(tx_b), .hdmitx_hsync_o(tx_hs),
        .hdmitx_vsync_o(tx_vs), .hdmitx_de_o(tx_de), .hdmitx_5v_en_o(tx_5v),
        .vga_r_o(v_r), .vga_g_o(v_g), .vga_b_o(v_b), .vga_hs_o(v_hs), .vga_vs_o(v_vs),
        .vga_blank_n_o(v_blank_n), .vga_sync_n_o(v_sync_n), .vga_oe_o(v_oe),
        .fan_pwm_n_o(fan_n), .led_o(led)
    );

    always #10 pclk_out = ~pclk_out;

    // Run limit
    always @(posedge pclk_out) begin
        cycles <= cycles + 1;
        if (cycles >= 20000) begin
            $display("Timeout: the test did not finish within 20000 clock cycles");
            $display("TEST FAILED");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    task automatic stop_on_error(input string msg);
        $display("ERROR @ %0t: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_pixel(input scan_out_pkg::pixel_t act, exp, input string what);
        if (act !== exp)
            stop_on_error($sformatf("%s got %h expected %h", what, act, exp));
    endtask

    task automatic check_resp(input scan_out_pkg::axi_resp_e act, exp, input string what);
        if (act !== exp)
            stop_on_error($sformatf("%s got %s expected %s", what, act.name(), exp.name()));
    endtask

    task automatic check_cfg(input scan_out_pkg::ctrl_cfg_t act, exp, input string what);
        if (act !== exp)
            stop_on_error($sformatf("%s got %h expected %h", what, act, exp));
    endtask

    task automatic check_bit(input logic act, exp, input string what);
        if (act !== exp)
            stop_on_error($sformatf("%s got %b expected %b", what, act, exp));
    endtask

    task automatic check_count(input int act, exp, input string what);
        if (act != exp)
            stop_on_error($sformatf("%s got %0d expected %0d", what, act, exp));
    endtask

    function automatic scan_out_pkg::pixel_t ref_hdmi_pix(scan_out_pkg::pixel_t p,
                                                          logic en, logic [2:0] c);
        scan_out_pkg::pixel_t o;
        o = p;
        if (en) begin
            o.r = c[2] ? 8'hff : 8'h00;
            o.g = c[1] ? 8'hff : 8'h00;
            o.b = c[0] ? 8'hff : 8'h00;
        end
        return o;
    endfunction

    // Returns hs, vs, blank_n, sync_n
    function automatic logic [3:0] ref_vga_sync(logic [1:0] mode, logic hs, vs, de);
        logic cs;
        cs = ~(hs ^ vs);
        if (mode == 2'd0) return {hs, vs, de, 1'b0};
        if (mode == 2'd1) return {cs, 1'b1, de, 1'b0};
        return {cs, 1'b1, de, cs};
    endfunction

    function automatic int ref_pwm_high(logic [3:0] duty);
        return duty * (`SO_PWM_PERIOD / 16);
    endfunction

    // Pipes expected values through the 2 and 3 cycle latencies
    always @(negedge pclk_out) begin
        logic [26:0] h;
        logic [27:0] v;
        scan_out_pkg::pixel_t p;
        p = ref_hdmi_pix({sc_r, sc_g, sc_b}, osd_en, osd_col);
        if (hdmi_chk) begin
            if (hq.size() >= 2) begin
                h = hq.pop_front();
                check_pixel({tx_r, tx_g, tx_b}, h[26:3], "hdmi pixel");
                check_bit(tx_hs, h[2], "hdmi hsync");
                check_bit(tx_vs, h[1], "hdmi vsync");
                check_bit(tx_de, h[0], "hdmi de");
                check_bit(tx_5v, cfg_model.poweron, "hdmi 5v enable");
            end
            hq.push_back({p, sc_hs, sc_vs, sc_de});
        end else begin
            hq.delete();
        end
        if (vga_chk) begin
            if (vq.size() >= 3) begin
                v = vq.pop_front();
                check_pixel({v_r, v_g, v_b}, v[27:4], "vga pixel");
                check_bit(v_hs, v[3], "vga hs");
                check_bit(v_vs, v[2], "vga vs");
                check_bit(v_blank_n, v[1], "vga blank_n");
                check_bit(v_sync_n, v[0], "vga sync_n");
                check_bit(v_oe, 1'b1, "vga oe");
            end
            vq.push_back({p, ref_vga_sync(cfg_model.extra_out_mode, sc_hs, sc_vs, sc_de)});
        end else begin
            vq.delete();
        end
    end

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        scan_out_pkg::axi_resp_e exp;
        logic [15:0] merged;
        int hold;
        exp = (addr == `SO_CTRL_ADDR) ? scan_out_pkg::OKAY : scan_out_pkg::SLVERR;
        hold = $random(seed) & 3;
        @(posedge pclk_out);
        awaddr <= addr;
        wdata <= data;
        wstrb <= strb;
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        do @(negedge pclk_out); while (!awready);
        check_bit(wready, 1'b1, "wready with awready");
        @(posedge pclk_out);
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        if (addr == `SO_CTRL_ADDR) begin
            merged = cfg_model;
            if (strb[0]) merged[7:0] = data[7:0];
            if (strb[1]) merged[15:8] = data[15:8];
            cfg_model = scan_out_pkg::ctrl_cfg_t'(merged);
            cfg_model.reserved = 2'b00;
        end
        repeat (hold) @(posedge pclk_out);
        bready <= 1'b1;
        do @(negedge pclk_out); while (!bvalid);
        check_resp(bresp, exp, "write response");
        @(posedge pclk_out);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr);
        int hold;
        hold = $random(seed) & 3;
        @(posedge pclk_out);
        araddr <= addr;
        arvalid <= 1'b1;
        do @(negedge pclk_out); while (!arready);
        @(posedge pclk_out);
        arvalid <= 1'b0;
        repeat (hold) @(posedge pclk_out);
        rready <= 1'b1;
        do @(negedge pclk_out); while (!rvalid);
        check_bit(|rdata[31:16], 1'b0, "read data upper half");
        if (addr == `SO_CTRL_ADDR) begin
            check_resp(rresp, scan_out_pkg::OKAY, "read response");
            check_cfg(rdata[15:0], cfg_model, "control register");
        end else begin
            check_resp(rresp, scan_out_pkg::SLVERR, "unmapped read response");
            check_cfg(rdata[15:0], '0, "unmapped read data");
        end
        @(posedge pclk_out);
        rready <= 1'b0;
    endtask

    task automatic set_cfg(input scan_out_pkg::ctrl_cfg_t c);
        axi_write(`SO_CTRL_ADDR, {16'h0000, c}, 4'b0011);
    endtask

    task automatic drive_video(input int n);
        repeat (n) begin
            @(posedge pclk_out);
            {sc_r, sc_g, sc_b} <= $random(seed);
            {sc_hs, sc_vs, sc_de, osd_col} <= $random(seed);
            osd_en <= (($random(seed) & 3) == 0);
        end
    endtask

    task automatic pwm_window(input scan_out_pkg::ctrl_cfg_t c);
        int fan_on, l2, l1, l0, on;
        fan_on = 0;
        l2 = 0;
        l1 = 0;
        l0 = 0;
        set_cfg(c);
        repeat (3) @(posedge pclk_out);
        repeat (`SO_PWM_PERIOD) begin
            @(negedge pclk_out);
            fan_on += !fan_n;
            l2 += led[2];
            l1 += led[1];
            l0 += led[0];
        end
        check_bit(tx_5v, c.poweron, "hdmi 5v enable");
        on = ref_pwm_high(c.led_duty);
        check_count(fan_on, c.poweron ? ref_pwm_high(c.fan_duty) : 0, "fan on count");
        check_count(l2, (c.poweron && c.framelock) ? on : 0, "led 2 count");
        check_count(l1, c.poweron ? on : 0, "led 1 count");
        check_count(l0, c.poweron ? 0 : on, "led 0 count");
    endtask

    initial begin
        scan_out_pkg::ctrl_cfg_t c;
        logic [27:0] held;
        int i;
        po_reset_n <= 1'b0;
        {awaddr, araddr, awvalid, wvalid, bready, arvalid, rready} <= '0;
        {wdata, wstrb} <= '0;
        {sc_r, sc_g, sc_b, sc_hs, sc_vs, sc_de, osd_en, osd_col} <= '0;
        repeat (4) @(posedge pclk_out);
        po_reset_n <= 1'b1;
        @(negedge pclk_out);
        check_bit(bvalid | rvalid | awready | wready | arready, 1'b0, "AXI idle after reset");
        check_bit(v_oe, 1'b0, "vga oe after reset");
        check_bit(fan_n, 1'b1, "fan off after reset");
        check_bit(|led, 1'b0, "leds after reset");

        // Register access with random strobes and unmapped addresses
        for (i = 0; i < 40; i++) begin
            if ($random(seed) & 1)
                axi_write(`SO_CTRL_ADDR, $random(seed), $random(seed));
            else
                axi_write(4'(4 + (($random(seed) & 3) % 3) * 4), $random(seed), 4'hf);
            axi_read(`SO_CTRL_ADDR);
            if ((i % 5) == 0) axi_read(4'h8);
        end

        // HDMI path and 5V enable
        c = '0;
        c.poweron = 1'b1;
        set_cfg(c);
        hdmi_chk = 1;
        drive_video(300);
        hdmi_chk = 0;

        // All four expansion modes
        for (i = 0; i < 4; i++) begin
            c.exp_sel = scan_out_pkg::EXTRA_OUT;
            c.extra_out_mode = scan_out_pkg::extra_out_mode_e'(i);
            set_cfg(c);
            hdmi_chk = 1;
            vga_chk = 1;
            drive_video(300);
            hdmi_chk = 0;
            vga_chk = 0;
        end

        // Expansion off and legacy input freeze the outputs
        for (i = 0; i < 2; i++) begin
            c.exp_sel = (i == 0) ? scan_out_pkg::OFF : scan_out_pkg::LEGACY_IN;
            set_cfg(c);
            @(negedge pclk_out);
            held = {v_r, v_g, v_b, v_hs, v_vs, v_blank_n, v_sync_n};
            drive_video(100);
            @(negedge pclk_out);
            check_bit(v_oe, 1'b0, "vga oe when disabled");
            check_bit(held == {v_r, v_g, v_b, v_hs, v_vs, v_blank_n, v_sync_n}, 1'b1,
                      "vga outputs held");
        end

        // PWM duties with power and framelock combinations
        for (i = 0; i < 8; i++) begin
            c = '0;
            c.poweron = i[0];
            c.framelock = i[1];
            c.fan_duty = 4'(i * 2 + 1);
            c.led_duty = (i == 7) ? 4'hf : 4'(15 - i * 3);
            pwm_window(c);
        end

        c = '0;
        set_cfg(c);
        pwm_window(c);
        axi_read(`SO_CTRL_ADDR);

        if (cycles < 20000) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+rtl
rtl/scan_out_pkg.sv
rtl/video_if.sv
rtl/ctrl_regs.sv
rtl/osd_mixer.sv
rtl/extra_out_encoder.sv
rtl/pwm_2ch.sv
rtl/scan_out_top.sv
sim/scan_out_asserts.sv
sim/scan_out_tb.sv
